// ==== filelist.f ====
+incdir+include
hw/pyr_pkg.sv
hw/pyr_frame_ram.sv
hw/pyr_blur3x3.sv
hw/pyr_half_decimator.sv
hw/pyr_sequencer.sv
hw/gaussian_pyramid.sv
tests/tb_gaussian_pyramid.sv

// ==== hw/gaussian_pyramid.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module gaussian_pyramid (
    input  logic              clk_in,
    input  logic              rst_in,
    input  logic              start_in,
    output pyr_pkg::ram_rd_t  src_rd,
    input  pyr_pkg::pixel_t   src_pixel,
    output pyr_pkg::pyr_out_t pyr_out,
    output logic              busy,
    output logic              pyramid_done
);
    import pyr_pkg::*;

    ram_wr_t src_wr;
    ram_wr_t blur_wr;
    ram_wr_t half_wr;
    ram_rd_t blur_rd_req;
    ram_rd_t half_rd_req;
    ram_rd_t blur_rd;
    ram_rd_t half_rd;
    pixel_t src_buf_data;
    pixel_t blur_buf_data;
    logic blur_start;
    logic blur_done;
    logic half_start;
    logic half_done;

    pyr_sequencer u_sequencer (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start_in     (start_in),
        .busy         (busy),
        .pyramid_done (pyramid_done),
        .src_rd       (src_rd),
        .src_pixel    (src_pixel),
        .src_wr       (src_wr),
        .blur_rd_req  (blur_rd_req),
        .blur_rd      (blur_rd),
        .half_rd_req  (half_rd_req),
        .half_rd      (half_rd),
        .blur_start   (blur_start),
        .half_start   (half_start),
        .blur_done    (blur_done),
        .half_done    (half_done),
        .blur_wr      (blur_wr),
        .half_wr      (half_wr),
        .pyr_out      (pyr_out)
    );

    // original image, filled by the loader
    pyr_frame_ram u_buf_src (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .wr      (src_wr),
        .rd      (blur_rd),
        .rd_data (src_buf_data)
    );

    // blurred image, read back by the decimator
    pyr_frame_ram u_buf_blur (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .wr      (blur_wr),
        .rd      (half_rd),
        .rd_data (blur_buf_data)
    );

    pyr_blur3x3 u_blur (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .start   (blur_start),
        .rd      (blur_rd_req),
        .rd_data (src_buf_data),
        .wr      (blur_wr),
        .done    (blur_done)
    );

    pyr_half_decimator u_half (
        .clk_in  (clk_in),
        .rst_in  (rst_in),
        .start   (half_start),
        .rd      (half_rd_req),
        .rd_data (blur_buf_data),
        .wr      (half_wr),
        .done    (half_done)
    );

endmodule

// ==== hw/pyr_blur3x3.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module pyr_blur3x3 (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             start,
    output pyr_pkg::ram_rd_t rd,
    input  pyr_pkg::pixel_t  rd_data,
    output pyr_pkg::ram_wr_t wr,
    output logic             done
);
    import pyr_pkg::*;

    typedef enum logic [1:0] {
        B_IDLE,
        B_READ,   // one neighbour read per cycle
        B_DRAIN   // last tap arrives, result goes out
    } blur_state_e;

    localparam int XW = $clog2(`PYR_TOP_W);
    localparam int YW = $clog2(`PYR_TOP_H);
    localparam int ACC_BITS = `PYR_PIX_BITS + 4; // 16 x max pixel plus rounding

    blur_state_e state;
    logic [XW-1:0] x;
    logic [YW-1:0] y;
    logic [1:0] tap_col;  // 0 left, 1 centre, 2 right
    logic [1:0] tap_row;  // 0 above, 1 centre, 2 below
    logic [1:0] shift_q;  // weight of the tap in flight, as a shift
    logic tap_vld_q;
    logic [ACC_BITS-1:0] acc;
    logic [ACC_BITS-1:0] acc_sum;
    logic last_tap;
    logic last_pix;
    int nb_x;
    int nb_y;

    // neighbour coordinate with the edge pixel repeated outside the image
    function automatic int clamp_nb(input int c, input logic [1:0] off, input int lim);
        int n;
        n = c + int'(off) - 1;
        if (n < 0) begin
            n = 0;
        end else if (n > lim) begin
            n = lim;
        end
        return n;
    endfunction

    assign last_tap = (tap_col == 2'd2) && (tap_row == 2'd2);
    assign last_pix = (x == XW'(`PYR_TOP_W - 1)) && (y == YW'(`PYR_TOP_H - 1));

    always_comb begin
        nb_x = clamp_nb(int'(x), tap_col, `PYR_TOP_W - 1);
        nb_y = clamp_nb(int'(y), tap_row, `PYR_TOP_H - 1);
        rd.en = (state == B_READ);
        rd.addr = addr_t'(nb_y * `PYR_TOP_W + nb_x);
    end

    // weights 1/2/4 folded into a shift of the returning pixel
    assign acc_sum = tap_vld_q ? acc + (ACC_BITS'(rd_data) << shift_q) : acc;

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= B_IDLE;
            x <= '0;
            y <= '0;
            tap_col <= '0;
            tap_row <= '0;
            tap_vld_q <= 1'b0;
            acc <= '0;
            wr.en <= 1'b0;
            done <= 1'b0;
        end else begin
            tap_vld_q <= (state == B_READ);
            shift_q <= 2'(tap_col == 2'd1) + 2'(tap_row == 2'd1);
            acc <= acc_sum;
            wr.en <= 1'b0;
            done <= 1'b0;
            case (state)
                B_IDLE: begin
                    if (start) begin
                        x <= '0;
                        y <= '0;
                        tap_col <= '0;
                        tap_row <= '0;
                        acc <= '0;
                        state <= B_READ;
                    end
                end
                B_READ: begin
                    if (tap_col == 2'd2) begin
                        tap_col <= '0;
                        tap_row <= tap_row + 2'd1;
                    end else begin
                        tap_col <= tap_col + 2'd1;
                    end
                    if (last_tap) begin
                        tap_row <= '0;
                        state <= B_DRAIN;
                    end
                end
                B_DRAIN: begin
                    wr.en <= 1'b1;
                    wr.addr <= addr_t'(int'(y) * `PYR_TOP_W + int'(x));
                    wr.data <= pixel_t'((acc_sum + ACC_BITS'(8)) >> 4); // round half up
                    acc <= '0;
                    if (last_pix) begin
                        done <= 1'b1; // lands with the final write
                        state <= B_IDLE;
                    end else begin
                        if (x == XW'(`PYR_TOP_W - 1)) begin
                            x <= '0;
                            y <= y + 1'b1;
                        end else begin
                            x <= x + 1'b1;
                        end
                        state <= B_READ;
                    end
                end
                default: state <= B_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/pyr_frame_ram.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module pyr_frame_ram (
    input  logic             clk_in,
    input  logic             rst_in,
    input  pyr_pkg::ram_wr_t wr,
    input  pyr_pkg::ram_rd_t rd,
    output pyr_pkg::pixel_t  rd_data
);
    import pyr_pkg::*;

    localparam int DEPTH = `PYR_TOP_W * `PYR_TOP_H;

    pixel_t mem [DEPTH];

    always_ff @(posedge clk_in) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // registered read port, data follows rd.en by one cycle
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_data <= '0;
        end else if (rd.en) begin
            rd_data <= mem[rd.addr];
        end
    end

endmodule

// ==== hw/pyr_half_decimator.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module pyr_half_decimator (
    input  logic             clk_in,
    input  logic             rst_in,
    input  logic             start,
    output pyr_pkg::ram_rd_t rd,
    input  pyr_pkg::pixel_t  rd_data,
    output pyr_pkg::ram_wr_t wr,
    output logic             done
);
    import pyr_pkg::*;

    typedef enum logic {
        D_IDLE,
        D_RUN
    } half_state_e;

    localparam int HW = `PYR_TOP_W / 2;
    localparam int HH = `PYR_TOP_H / 2;
    localparam int XW = $clog2(HW);
    localparam int YW = $clog2(HH);

    half_state_e state;
    logic [XW-1:0] ox;  // output grid position
    logic [YW-1:0] oy;
    logic last_cell;
    logic rd_vld_q;
    addr_t out_addr_q;

    assign last_cell = (ox == XW'(HW - 1)) && (oy == YW'(HH - 1));

    always_comb begin
        rd.en = (state == D_RUN);
        rd.addr = addr_t'(2 * int'(oy) * `PYR_TOP_W + 2 * int'(ox)); // even row, even column
        wr.en = rd_vld_q;
        wr.addr = out_addr_q;
        wr.data = rd_data;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state <= D_IDLE;
            ox <= '0;
            oy <= '0;
            rd_vld_q <= 1'b0;
            done <= 1'b0;
        end else begin
            rd_vld_q <= rd.en;
            done <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (start) begin
                        ox <= '0;
                        oy <= '0;
                        state <= D_RUN;
                    end
                end
                D_RUN: begin
                    if (last_cell) begin
                        done <= 1'b1; // same cycle as the last write
                        state <= D_IDLE;
                    end
                    if (ox == XW'(HW - 1)) begin
                        ox <= '0;
                        oy <= oy + 1'b1;
                    end else begin
                        ox <= ox + 1'b1;
                    end
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        out_addr_q <= addr_t'(int'(oy) * HW + int'(ox));
    end

endmodule

// ==== hw/pyr_pkg.sv ====
`include "pyr_params.svh"

package pyr_pkg;

    typedef logic [`PYR_PIX_BITS-1:0] pixel_t;
    typedef logic [`PYR_TOP_ADDR_BITS-1:0] addr_t;

    // sequencer stages, one per pyramid step
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        BLUR,
        HALVE
    } pyr_stage_e;

    // tag carried by every output write
    typedef enum logic [1:0] {
        O1L1,  // original image
        O1L2,  // blurred image
        O2L1   // halved blurred image
    } pyr_level_e;

    typedef struct packed {
        logic   en;
        addr_t  addr;
        pixel_t data;
    } ram_wr_t;

    typedef struct packed {
        logic  en;
        addr_t addr;
    } ram_rd_t;

    typedef struct packed {
        logic       valid;
        pyr_level_e level;
        addr_t      addr;
        pixel_t     data;
    } pyr_out_t;

endpackage

// ==== hw/pyr_sequencer.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module pyr_sequencer (
    input  logic               clk_in,
    input  logic               rst_in,
    input  logic               start_in,
    output logic               busy,
    output logic               pyramid_done,
    output pyr_pkg::ram_rd_t   src_rd,
    input  pyr_pkg::pixel_t    src_pixel,
    output pyr_pkg::ram_wr_t   src_wr,
    input  pyr_pkg::ram_rd_t   blur_rd_req,  // blur engine request
    output pyr_pkg::ram_rd_t   blur_rd,      // to the source buffer
    input  pyr_pkg::ram_rd_t   half_rd_req,  // decimator request
    output pyr_pkg::ram_rd_t   half_rd,      // to the blurred buffer
    output logic               blur_start,
    output logic               half_start,
    input  logic               blur_done,
    input  logic               half_done,
    input  pyr_pkg::ram_wr_t   blur_wr,
    input  pyr_pkg::ram_wr_t   half_wr,
    output pyr_pkg::pyr_out_t  pyr_out
);
    import pyr_pkg::*;

    localparam addr_t LAST_ADDR = addr_t'(`PYR_TOP_W * `PYR_TOP_H - 1);

    pyr_stage_e stage;
    logic ld_issue;       // loader still has addresses to send
    addr_t ld_addr;
    logic [1:0] ld_vld;   // matches the two-cycle source memory latency
    addr_t ld_addr_d1;
    addr_t ld_addr_d2;

    assign busy = (stage != IDLE);

    always_comb begin
        src_rd.en = (stage == LOAD) && ld_issue;
        src_rd.addr = ld_addr;
        src_wr.en = ld_vld[1];
        src_wr.addr = ld_addr_d2;
        src_wr.data = src_pixel;
        blur_rd.en = blur_rd_req.en && (stage == BLUR);
        blur_rd.addr = blur_rd_req.addr;
        half_rd.en = half_rd_req.en && (stage == HALVE);
        half_rd.addr = half_rd_req.addr;
    end

    // shared output port follows the stage, each writer with its own level
    always_comb begin
        pyr_out = '0;
        case (stage)
            LOAD:  pyr_out = '{valid: src_wr.en, level: O1L1, addr: src_wr.addr,
                               data: src_wr.data};
            BLUR:  pyr_out = '{valid: blur_wr.en, level: O1L2, addr: blur_wr.addr,
                               data: blur_wr.data};
            HALVE: pyr_out = '{valid: half_wr.en, level: O2L1, addr: half_wr.addr,
                               data: half_wr.data};
            default: ;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            stage <= IDLE;
            ld_issue <= 1'b0;
            ld_addr <= '0;
            ld_vld <= '0;
            blur_start <= 1'b0;
            half_start <= 1'b0;
            pyramid_done <= 1'b0;
        end else begin
            ld_vld <= {ld_vld[0], src_rd.en};
            blur_start <= 1'b0;
            half_start <= 1'b0;
            pyramid_done <= 1'b0;
            if (src_rd.en) begin
                ld_addr <= ld_addr + 1'b1;
                if (ld_addr == LAST_ADDR) begin
                    ld_issue <= 1'b0;
                end
            end
            case (stage)
                IDLE: begin
                    if (start_in) begin
                        stage <= LOAD;
                        ld_issue <= 1'b1;
                        ld_addr <= '0;
                    end
                end
                LOAD: begin
                    if (ld_vld[1] && (ld_addr_d2 == LAST_ADDR)) begin
                        stage <= BLUR;
                        blur_start <= 1'b1;
                    end
                end
                BLUR: begin
                    if (blur_done) begin
                        stage <= HALVE;
                        half_start <= 1'b1;
                    end
                end
                HALVE: begin
                    if (half_done) begin
                        stage <= IDLE;
                        pyramid_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        ld_addr_d1 <= ld_addr;
        ld_addr_d2 <= ld_addr_d1;
    end

endmodule

// ==== include/pyr_params.svh ====
`ifndef PYR_PARAMS_SVH
`define PYR_PARAMS_SVH

// greyscale pixel depth
`define PYR_PIX_BITS 8

// top image geometry, octave 1
`define PYR_TOP_W 8
`define PYR_TOP_H 8

// enough to address every top image pixel
`define PYR_TOP_ADDR_BITS 6

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the gaussian pyramid testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f filelist.f \
    --top-module tb_gaussian_pyramid \
    -o sim_tb

./obj_dir/sim_tb | tee "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed, see $LOG"
    exit 1
fi

// ==== tests/tb_gaussian_pyramid.sv ====
`timescale 1ns/1ps
`include "pyr_params.svh"

module tb_gaussian_pyramid;
    import pyr_pkg::*;

    localparam int NPIX = `PYR_TOP_W * `PYR_TOP_H;
    localparam int HALF_W = `PYR_TOP_W / 2;
    localparam int NHALF = HALF_W * (`PYR_TOP_H / 2);

    logic clk_in = 1'b0;
    logic rst_in;
    logic start_in;
    ram_rd_t src_rd;
    pixel_t src_pixel = '0;
    pyr_out_t pyr_out;
    logic busy;
    logic pyramid_done;

    pixel_t src_img [NPIX];
    pixel_t exp_blur [NPIX];
    pixel_t exp_half [NHALF];
    pixel_t rd_pipe1 = '0;
    pixel_t rd_pipe2 = '0;
    int wr_count [3];  // writes seen per level
    int err_cat [4];   // errors per level, last one for control
    int err_total;
    int done_seen;
    int tests_passed;
    int tests_failed;

    always #2 clk_in = ~clk_in;

    gaussian_pyramid u_gaussian_pyramid (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .start_in     (start_in),
        .src_rd       (src_rd),
        .src_pixel    (src_pixel),
        .pyr_out      (pyr_out),
        .busy         (busy),
        .pyramid_done (pyramid_done)
    );

    // external source memory, pixel arrives two cycles after the request
    always @(posedge clk_in) begin
        if (src_rd.en) begin
            rd_pipe1 <= src_img[src_rd.addr];
        end
        rd_pipe2 <= rd_pipe1;
    end

    always @(negedge clk_in) begin
        src_pixel <= rd_pipe2;
    end

    function automatic int clamp_coord(input int c, input int lim);
        if (c < 0) begin
            return 0;
        end
        return (c > lim) ? lim : c;
    endfunction

    function automatic int level_size(input int lvl);
        return (lvl == 2) ? NHALF : NPIX;
    endfunction

    // 1 2 1 / 2 4 2 / 1 2 1 with edge repeat, then every second pixel of every second row
    task automatic compute_expected();
        int sum;
        int nx;
        int ny;
        int wgt;
        for (int y = 0; y < `PYR_TOP_H; y++) begin
            for (int x = 0; x < `PYR_TOP_W; x++) begin
                sum = 0;
                for (int dy = -1; dy <= 1; dy++) begin
                    for (int dx = -1; dx <= 1; dx++) begin
                        nx = clamp_coord(x + dx, `PYR_TOP_W - 1);
                        ny = clamp_coord(y + dy, `PYR_TOP_H - 1);
                        wgt = ((dx == 0) ? 2 : 1) * ((dy == 0) ? 2 : 1);
                        sum += wgt * int'(src_img[ny * `PYR_TOP_W + nx]);
                    end
                end
                exp_blur[y * `PYR_TOP_W + x] = pixel_t'((sum + 8) / 16);
            end
        end
        for (int hy = 0; hy < `PYR_TOP_H / 2; hy++) begin
            for (int hx = 0; hx < HALF_W; hx++) begin
                exp_half[hy * HALF_W + hx] = exp_blur[2 * hy * `PYR_TOP_W + 2 * hx];
            end
        end
    endtask

    task automatic flag_error(input int cat, input string msg);
        $display("ERR @%0t: %s", $time, msg);
        err_total++;
        err_cat[cat]++;
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic check_write(input pyr_out_t w);
        int lvl;
        int n;
        pixel_t want;
        lvl = int'(w.level);
        if (lvl > 2) begin
            flag_error(3, $sformatf("write with unknown level tag %0d", lvl));
        end else begin
            n = wr_count[lvl];
            if (n >= level_size(lvl)) begin
                flag_error(lvl, $sformatf("extra write at level %0d, addr %0d", lvl, w.addr));
            end else begin
                case (lvl)
                    0: want = src_img[n];
                    1: want = exp_blur[n];
                    default: want = exp_half[n];
                endcase
                assert (int'(w.addr) == n)
                    else flag_error(lvl, $sformatf("level %0d addr %0d, expected %0d",
                                                   lvl, w.addr, n));
                assert (w.data == want)
                    else flag_error(lvl, $sformatf("level %0d addr %0d data %0d, expected %0d",
                                                   lvl, n, w.data, want));
                assert (lvl == 0 || wr_count[lvl - 1] == level_size(lvl - 1))
                    else flag_error(lvl, $sformatf("level %0d began too early", lvl));
            end
            wr_count[lvl] = n + 1;
        end
    endtask

    // output port monitor, values taken as the DUT's own flops see them
    always @(posedge clk_in) begin
        if (!rst_in) begin
            if (pyr_out.valid) begin
                check_write(pyr_out);
            end
            if (pyramid_done) begin
                done_seen++;
                assert (wr_count[2] == NHALF)
                    else flag_error(3, "pyramid_done before the last O2L1 write");
                assert (done_seen == 1) else flag_error(3, "pyramid_done pulsed again");
            end
        end
    end

    assert property (@(posedge clk_in) disable iff (rst_in) pyramid_done |-> !busy)
        else flag_error(3, "pyramid_done while busy");
    assert property (@(posedge clk_in) disable iff (rst_in) pyr_out.valid |-> busy)
        else flag_error(3, "output write while idle");
    assert property (@(posedge clk_in) disable iff (rst_in) src_rd.en |-> busy)
        else flag_error(3, "source memory read while idle");

    task automatic check_quiet(input string when_txt);
        assert (!busy && !pyramid_done && !pyr_out.valid && !src_rd.en)
            else flag_error(3, $sformatf("outputs active %s", when_txt));
    endtask

    task automatic pulse_start();
        @(negedge clk_in);
        start_in = 1'b1;
        @(negedge clk_in);
        start_in = 1'b0;
    endtask

    task automatic wait_for_busy();
        int cycles;
        cycles = 0;
        while (!busy && cycles < 8) begin
            @(negedge clk_in);
            cycles++;
        end
        if (!busy) begin
            abort_run("timeout: busy never rose after the start pulse");
        end
    endtask

    task automatic wait_for_writes(input int lvl, input int n);
        int cycles;
        cycles = 0;
        while (wr_count[lvl] < n && cycles < 2000) begin
            @(negedge clk_in);
            cycles++;
        end
        if (wr_count[lvl] < n) begin
            abort_run($sformatf("timeout: only %0d writes seen at level %0d", wr_count[lvl], lvl));
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        while (done_seen == 0 && cycles < 5000) begin
            @(negedge clk_in);
            cycles++;
        end
        if (done_seen == 0) begin
            abort_run("timeout: pyramid_done never pulsed");
        end
    endtask

    task automatic run_pyramid(input bit poke_busy);
        for (int i = 0; i < NPIX; i++) begin
            src_img[i] = pixel_t'($urandom);
        end
        compute_expected();
        wr_count = '{0, 0, 0};
        err_cat = '{0, 0, 0, 0};
        done_seen = 0;
        pulse_start();
        wait_for_busy();
        if (poke_busy) begin
            wait_for_writes(0, 20);
            pulse_start();  // ignored in LOAD
            wait_for_writes(1, 10);
            pulse_start();
            wait_for_writes(2, 4);
            pulse_start();
        end
        wait_for_done();
        repeat (30) @(negedge clk_in);  // any restart or late write shows up here
        assert (!busy) else flag_error(3, "busy high again after pyramid_done");
        assert (done_seen == 1)
            else flag_error(3, $sformatf("pyramid_done pulsed %0d times", done_seen));
        for (int i = 0; i < 3; i++) begin
            assert (wr_count[i] == level_size(i))
                else flag_error(i, $sformatf("level %0d got %0d writes", i, wr_count[i]));
        end
    endtask

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errs);
        end
    endtask

    initial begin
        rst_in = 1'b1;
        start_in = 1'b0;
        err_total = 0;
        done_seen = 0;
        tests_passed = 0;
        tests_failed = 0;
        wr_count = '{0, 0, 0};
        err_cat = '{0, 0, 0, 0};
        void'($urandom(78847));

        repeat (2) begin
            @(negedge clk_in);
            check_quiet("during reset");
        end
        rst_in = 1'b0;
        repeat (6) begin
            @(negedge clk_in);
            check_quiet("after reset, before start");
        end
        report_test("test 1 reset and idle outputs", err_total);

        run_pyramid(1'b1);
        report_test("test 2 O1L1 copy of the source", err_cat[0]);
        report_test("test 3 O1L2 blurred image", err_cat[1]);
        report_test("test 4 O2L1 halved image", err_cat[2]);
        report_test("test 5 single done, start while busy", err_cat[3]);

        run_pyramid(1'b0);
        report_test("test 6 second run, new image",
                    err_cat[0] + err_cat[1] + err_cat[2] + err_cat[3]);

        $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
                 err_total);
        if (tests_failed == 0 && err_total == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule
